// File: bench/aes_round_ctrl_input.txt
// key_len (one-hot, hex)  out_ready delay in cycles (hex)  fault kind
// fault: 0 none, 1 bad key length, 2 bad in_valid code, 3 fatal alert pulse
1 0 0
2 0 0
4 0 0
1 3 0
2 5 0
4 1 0
4 7 0
1 2 0
2 0 0
3 0 1
0 2 1
1 0 2
4 1 2
2 0 3
4 3 3
1 0 0
6 1 1
4 2 0

// File: project.f
hdl/aes_ctrl_pkg.sv
hdl/aes_sp2v_chk.sv
hdl/aes_round_rail.sv
hdl/aes_rail_combine.sv
hdl/aes_round_ctrl.sv
bench/tb_aes_round_ctrl.sv

// File: run.sh
#!/bin/sh
# Compile and run the round sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_aes_round_ctrl -f project.f \
    --Mdir obj_dir -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: bench/tb_aes_round_ctrl.sv
// Testbench for the AES round sequencer
// Vectors from the input file, per-cycle command checks, back-pressure,
// fault injection and a cycle watchdog

`timescale 1ns/1ns

module tb_aes_round_ctrl import aes_ctrl_pkg::*; ();

  localparam int MaxVec = 32;

  logic         clk_i = 1'b0;
  logic         rst_ni;
  sp2v_e        in_valid_i;
  sp2v_e        in_ready_o;
  sp2v_e        out_valid_o;
  sp2v_e        out_ready_i;
  key_len_e     key_len_i;
  logic         alert_fatal_i;
  logic         alert_o;
  cipher_ctrl_t ctrl_o;

  logic [7:0]   vec_mem [3*MaxVec];  // Key, delay, fault per vector
  int           seed        = 51201;
  int           cycle_cnt   = 0;
  int           cycle_limit = 1000000;

  aes_round_ctrl aes_round_ctrl_i (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .in_valid_i    ( in_valid_i    ),
    .in_ready_o    ( in_ready_o    ),
    .out_valid_o   ( out_valid_o   ),
    .out_ready_i   ( out_ready_i   ),
    .key_len_i     ( key_len_i     ),
    .alert_fatal_i ( alert_fatal_i ),
    .alert_o       ( alert_o       ),
    .ctrl_o        ( ctrl_o        )
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: the run went past its limit of %0d cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Watchdog expired");
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Reference values and checking
  //////////////////////////////////////////////////////////////////////////

  function automatic int rounds_for_key(input logic [7:0] key);
    int n;
    case (key)
      8'h01:   n = 10;
      8'h02:   n = 12;
      8'h04:   n = 14;
      default: n = 0;  // Not a legal key length
    endcase
    return n;
  endfunction

  // Commands for a given cycle offset after acceptance
  function automatic cipher_ctrl_t expected_ctrl(input int offset, input int n);
    cipher_ctrl_t c;
    c = '0;
    if (offset == 0) begin
      c.state_sel  = STATE_INIT;
      c.state_we   = 1'b1;
      c.add_rk_sel = ADD_RK_INIT;
    end else if (offset < n) begin
      c.state_sel     = STATE_ROUND;
      c.state_we      = 1'b1;
      c.add_rk_sel    = ADD_RK_ROUND;
      c.key_expand_en = 1'b1;
      c.rnd_ctr       = offset[RndCtrWidth-1:0];
    end else if (offset == n) begin
      c.state_sel     = STATE_FINAL;
      c.state_we      = 1'b1;
      c.add_rk_sel    = ADD_RK_FINAL;
      c.key_expand_en = 1'b1;
      c.rnd_ctr       = n[RndCtrWidth-1:0];
    end
    return c;
  endfunction

  function automatic logic [31:0] sp_word(input sp2v_e v);
    return {29'd0, v};
  endfunction

  function automatic logic [31:0] ctrl_word(input cipher_ctrl_t c);
    return {20'd0, c};
  endfunction

  task automatic check_val(input string name, input logic [31:0] act,
                           input logic [31:0] exp);
    if (act !== exp) begin
      $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, act, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////////

  task automatic drive_idle();
    in_valid_i    = SP2V_LOW;
    out_ready_i   = SP2V_LOW;
    key_len_i     = AES_128;
    alert_fatal_i = 1'b0;
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    drive_idle();
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    #10;
    check_val("in_ready_o", sp_word(in_ready_o), sp_word(SP2V_HIGH));
    check_val("out_valid_o", sp_word(out_valid_o), sp_word(SP2V_LOW));
    check_val("alert_o", {31'd0, alert_o}, 32'd0);
    check_val("ctrl_o", ctrl_word(ctrl_o), 32'd0);
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) begin
      @(negedge clk_i);
      drive_idle();
      #10;
      check_val("in_ready_o", sp_word(in_ready_o), sp_word(SP2V_HIGH));
      check_val("out_valid_o", sp_word(out_valid_o), sp_word(SP2V_LOW));
      check_val("ctrl_o", ctrl_word(ctrl_o), 32'd0);
    end
  endtask

  // One block from acceptance to the output handshake
  task automatic run_block(input logic [7:0] key, input int n, input int delay);
    int offset;
    int we_cnt;
    int out_cnt;
    bit done;
    offset  = 0;
    we_cnt  = 0;
    out_cnt = 0;
    done    = 1'b0;
    @(negedge clk_i);
    in_valid_i = SP2V_HIGH;
    key_len_i  = key_len_e'(key[2:0]);
    #10;
    while (!done) begin
      check_val("alert_o", {31'd0, alert_o}, 32'd0);
      if (out_valid_o == SP2V_HIGH) begin
        if (out_cnt == 0) begin
          check_val("out_valid_o latency", offset, n + 1);
        end
        check_val("in_ready_o", sp_word(in_ready_o), sp_word(SP2V_LOW));
        check_val("ctrl_o", ctrl_word(ctrl_o), 32'd0);
        done    = (out_ready_i == SP2V_HIGH);  // Handshake in this cycle
        out_cnt = out_cnt + 1;
      end else begin
        check_val("ctrl_o", ctrl_word(ctrl_o), ctrl_word(expected_ctrl(offset, n)));
        check_val("in_ready_o", sp_word(in_ready_o),
                  sp_word(offset == 0 ? SP2V_HIGH : SP2V_LOW));
        if (ctrl_o.state_we) begin
          we_cnt = we_cnt + 1;
        end
      end
      @(negedge clk_i);
      in_valid_i = SP2V_LOW;
      // out_valid_o only depends on state, so it is settled at the falling edge
      if (!done && out_valid_o == SP2V_HIGH && out_cnt >= delay) begin
        out_ready_i = SP2V_HIGH;
      end else begin
        out_ready_i = SP2V_LOW;
      end
      #10;
      offset = offset + 1;
    end
    check_val("state_we cycles", we_cnt, n + 1);
    check_val("in_ready_o", sp_word(in_ready_o), sp_word(SP2V_HIGH));
    check_val("out_valid_o", sp_word(out_valid_o), sp_word(SP2V_LOW));
  endtask

  // Inject one fault, then keep driving traffic that must be ignored
  task automatic run_fault(input logic [7:0] key, input int kind, input int hold);
    @(negedge clk_i);
    case (kind)
      1: begin
        in_valid_i = SP2V_HIGH;
        key_len_i  = key_len_e'(key[2:0]);
      end
      2:       in_valid_i = sp2v_e'(3'b111);  // Splits the rails as well
      default: alert_fatal_i = 1'b1;
    endcase
    #10;
    check_val("alert_o", {31'd0, alert_o}, 32'd0);
    for (int j = 0; j < hold; j++) begin
      @(negedge clk_i);
      alert_fatal_i = 1'b0;
      in_valid_i    = (j % 2 == 0) ? SP2V_HIGH : SP2V_LOW;
      key_len_i     = AES_256;
      out_ready_i   = SP2V_HIGH;
      #10;
      check_val("alert_o", {31'd0, alert_o}, 32'd1);
      check_val("in_ready_o", sp_word(in_ready_o), sp_word(SP2V_LOW));
      check_val("out_valid_o", sp_word(out_valid_o), sp_word(SP2V_LOW));
      check_val("ctrl_o.state_we", {31'd0, ctrl_o.state_we}, 32'd0);
      check_val("ctrl_o.key_expand_en", {31'd0, ctrl_o.key_expand_en}, 32'd0);
    end
    drive_idle();
  endtask

  task automatic run_vectors(input int num_vec);
    int limit;
    int gaps [MaxVec];
    int n;
    int delay;
    int fault;
    bit after_fault;
    logic [7:0] key;
    limit = 5;
    for (int i = 0; i < num_vec; i++) begin
      gaps[i] = $unsigned($random(seed)) % 4;
      n = rounds_for_key(vec_mem[3*i]);
      if (n == 0) begin
        n = 14;
      end
      limit = limit + n + 32'(vec_mem[3*i+1]) + gaps[i] + 20;
    end
    cycle_limit = limit;

    apply_reset();
    after_fault = 1'b0;
    for (int i = 0; i < num_vec; i++) begin
      key   = vec_mem[3*i];
      delay = 32'(vec_mem[3*i+1]);
      fault = 32'(vec_mem[3*i+2]);
      if (fault != 0 || after_fault) begin
        apply_reset();  // Only reset leaves the error state
      end
      if (fault == 0) begin
        idle_cycles(gaps[i]);
        run_block(key, rounds_for_key(key), delay);
      end else begin
        run_fault(key, fault, 4 + delay);
      end
      after_fault = (fault != 0);
    end
  endtask

  initial begin : main_seq
    int num_vec;
    rst_ni = 1'b0;
    drive_idle();
    for (int i = 0; i < 3*MaxVec; i++) begin
      vec_mem[i] = 8'hff;  // End marker
    end
    $readmemh("bench/aes_round_ctrl_input.txt", vec_mem);
    num_vec = 0;
    while (num_vec < MaxVec && vec_mem[3*num_vec] != 8'hff) begin
      num_vec = num_vec + 1;
    end
    if (num_vec == 0) begin
      $display("No test vectors were found in the input file");
      $display("TEST RESULT: FAIL");
      $fatal(1, "Empty stimulus");
    end else begin
      run_vectors(num_vec);
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: hdl/aes_round_ctrl.sv
// AES round sequencer, top level
// Encoding checker, three redundant control rails and the rail combiner

`timescale 1ns/1ns

module aes_round_ctrl import aes_ctrl_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,

  // Input handshake
  input  sp2v_e         in_valid_i,
  output sp2v_e         in_ready_o,

  // Output handshake
  output sp2v_e         out_valid_o,
  input  sp2v_e         out_ready_i,

  input  key_len_e      key_len_i,    // Sampled at acceptance

  input  logic          alert_fatal_i,
  output logic          alert_o,

  output cipher_ctrl_t  ctrl_o        // Datapath commands
);

  // Per-rail inputs from the checker
  rail_in_t     [Sp2VWidth-1:0] rail_in;
  logic                         sp_enc_err;

  // Rail outputs
  logic         [Sp2VWidth-1:0] sp_in_ready;
  logic         [Sp2VWidth-1:0] sp_out_valid;
  cipher_ctrl_t [Sp2VWidth-1:0] rail_ctrl;
  logic         [Sp2VWidth-1:0] rail_alert;

  logic                         mr_err;

  ////////////////////////////////////////////////////////////////////////////
  // Input encoding check
  ////////////////////////////////////////////////////////////////////////////

  aes_sp2v_chk aes_sp2v_chk_i (
    .in_valid_i   ( in_valid_i     ),
    .out_ready_i  ( out_ready_i    ),
    .key_len_i    ( key_len_i      ),
    .accept_i     ( sp_in_ready[0] ),
    .rail_in_o    ( rail_in        ),
    .sp_enc_err_o ( sp_enc_err     )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Redundant rails
  ////////////////////////////////////////////////////////////////////////////

  // Rail polarity follows the bit pattern of SP2V_HIGH
  for (genvar i = 0; i < Sp2VWidth; i++) begin : gen_rail
    aes_round_rail #(
      .ActiveHigh ( SP2V_LOGIC_HIGH[i] )
    ) aes_round_rail_i (
      .clk_i         ( clk_i           ),
      .rst_ni        ( rst_ni          ),
      .rail_in_i     ( rail_in[i]      ),
      .key_len_i     ( key_len_i       ),
      .sp_enc_err_i  ( sp_enc_err      ),
      .mr_err_i      ( mr_err          ),
      .alert_fatal_i ( alert_fatal_i   ),
      .in_ready_o    ( sp_in_ready[i]  ), // Gathered into sparse output
      .out_valid_o   ( sp_out_valid[i] ), // Gathered into sparse output
      .ctrl_o        ( rail_ctrl[i]    ), // OR-combined
      .alert_o       ( rail_alert[i]   )  // OR-combined
    );
  end

  // Rail bits form the sparse handshake outputs directly
  assign in_ready_o  = sp2v_e'(sp_in_ready);
  assign out_valid_o = sp2v_e'(sp_out_valid);

  ////////////////////////////////////////////////////////////////////////////
  // Rail combination
  ////////////////////////////////////////////////////////////////////////////

  aes_rail_combine aes_rail_combine_i (
    .rail_ctrl_i  ( rail_ctrl  ),
    .rail_alert_i ( rail_alert ),
    .ctrl_o       ( ctrl_o     ),
    .alert_o      ( alert_o    ),
    .mr_err_o     ( mr_err     )  // Back to every rail
  );

endmodule

// File: hdl/aes_rail_combine.sv
// Combiner for the rail outputs
// OR of the command structs and alerts, plus rail mismatch detection

`timescale 1ns/1ns

module aes_rail_combine import aes_ctrl_pkg::*; (
  input  cipher_ctrl_t [Sp2VWidth-1:0]  rail_ctrl_i,
  input  logic         [Sp2VWidth-1:0]  rail_alert_i,

  output cipher_ctrl_t                  ctrl_o,
  output logic                          alert_o,
  output logic                          mr_err_o
);

  logic [$bits(cipher_ctrl_t)-1:0] ctrl_or;
  logic [Sp2VWidth-1:0]            rail_diff;

  ////////////////////////////////////////////////////////////////////////////
  // OR combination
  ////////////////////////////////////////////////////////////////////////////

  // A single active rail is enough to set an output bit
  always_comb begin : combine_ctrl
    ctrl_or = '0;
    for (int i = 0; i < Sp2VWidth; i++) begin
      ctrl_or = ctrl_or | rail_ctrl_i[i];
    end
  end

  assign ctrl_o = cipher_ctrl_t'(ctrl_or);

  assign alert_o = |rail_alert_i;

  ////////////////////////////////////////////////////////////////////////////
  // Mismatch detection
  ////////////////////////////////////////////////////////////////////////////

  // A rail that differs from the OR result disagrees with at least one other
  // rail, even when the OR itself still forms a valid one-hot code
  always_comb begin : compare_rails
    for (int i = 0; i < Sp2VWidth; i++) begin
      rail_diff[i] = (rail_ctrl_i[i] != ctrl_or);
    end
  end

  assign mr_err_o = |rail_diff;

endmodule

// File: hdl/aes_round_rail.sv
// One rail of the AES round control FSM
// Round counter, round limit register and terminal error state

`timescale 1ns/1ns

module aes_round_rail import aes_ctrl_pkg::*; #(
  parameter bit ActiveHigh = 1'b1 // Polarity of this rail's handshake bits
) (
  input  logic          clk_i,
  input  logic          rst_ni,

  input  rail_in_t      rail_in_i,
  input  key_len_e      key_len_i,

  input  logic          sp_enc_err_i,
  input  logic          mr_err_i,
  input  logic          alert_fatal_i,

  output logic          in_ready_o,
  output logic          out_valid_o,
  output cipher_ctrl_t  ctrl_o,
  output logic          alert_o
);

  // Round counts per key length
  localparam logic [RndCtrWidth-1:0] NumRnd128 = 4'd10;
  localparam logic [RndCtrWidth-1:0] NumRnd192 = 4'd12;
  localparam logic [RndCtrWidth-1:0] NumRnd256 = 4'd14;

  // Codes at Hamming distance 3 or more, anything else lands in ERROR
  typedef enum logic [5:0] {
    IDLE  = 6'b001001,
    ROUND = 6'b010011,
    FINAL = 6'b100110,
    OUT   = 6'b011100,
    ERROR = 6'b110101
  } rail_state_e;

  rail_state_e            state_d, state_q;
  logic [RndCtrWidth-1:0] rnd_ctr_d, rnd_ctr_q;
  logic [RndCtrWidth-1:0] rnd_lim_d, rnd_lim_q;
  logic [RndCtrWidth-1:0] rnd_lim_new;

  logic                   in_valid;
  logic                   out_ready;
  logic                   in_ready;
  logic                   out_valid;
  logic                   err;

  ////////////////////////////////////////////////////////////////////////////
  // Rail polarity
  ////////////////////////////////////////////////////////////////////////////

  assign in_valid  = ActiveHigh ? rail_in_i.in_valid  : ~rail_in_i.in_valid;
  assign out_ready = ActiveHigh ? rail_in_i.out_ready : ~rail_in_i.out_ready;

  assign in_ready_o  = ActiveHigh ? in_ready  : ~in_ready;
  assign out_valid_o = ActiveHigh ? out_valid : ~out_valid;

  assign err = sp_enc_err_i | mr_err_i | alert_fatal_i;

  // Round limit for the block being accepted
  always_comb begin : rnd_lim_sel
    case (key_len_i)
      AES_192: rnd_lim_new = NumRnd192;
      AES_256: rnd_lim_new = NumRnd256;
      default: rnd_lim_new = NumRnd128; // Invalid codes raise sp_enc_err
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : fsm_comb
    state_d   = state_q;
    rnd_ctr_d = rnd_ctr_q;
    rnd_lim_d = rnd_lim_q;
    in_ready  = 1'b0;
    out_valid = 1'b0;
    alert_o   = 1'b0;
    ctrl_o    = '0;

    case (state_q)
      IDLE: begin
        in_ready = 1'b1;
        if (in_valid) begin
          // Initial AddRoundKey in the acceptance cycle
          ctrl_o.state_sel  = STATE_INIT;
          ctrl_o.state_we   = 1'b1;
          ctrl_o.add_rk_sel = ADD_RK_INIT;
          rnd_ctr_d         = 4'd1;
          rnd_lim_d         = rnd_lim_new;
          state_d           = ROUND;
        end
      end

      ROUND: begin
        ctrl_o.state_sel     = STATE_ROUND;
        ctrl_o.state_we      = 1'b1;
        ctrl_o.add_rk_sel    = ADD_RK_ROUND;
        ctrl_o.key_expand_en = 1'b1;
        ctrl_o.rnd_ctr       = rnd_ctr_q;
        rnd_ctr_d            = rnd_ctr_q + 4'd1;
        if (rnd_ctr_q == rnd_lim_q - 4'd1) begin
          state_d = FINAL;
        end
      end

      FINAL: begin
        // Last round key is still expanded here
        ctrl_o.state_sel     = STATE_FINAL;
        ctrl_o.state_we      = 1'b1;
        ctrl_o.add_rk_sel    = ADD_RK_FINAL;
        ctrl_o.key_expand_en = 1'b1;
        ctrl_o.rnd_ctr       = rnd_ctr_q;
        state_d              = OUT;
      end

      OUT: begin
        out_valid = 1'b1; // Held under back-pressure
        if (out_ready) begin
          rnd_ctr_d = '0;
          state_d   = IDLE;
        end
      end

      ERROR: begin
        alert_o = 1'b1; // Terminal, left only by reset
      end

      default: begin
        state_d = ERROR;
      end
    endcase

    // Any error overrides the regular next state
    if (err) begin
      state_d = ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_regs
    if (!rst_ni) begin
      state_q   <= IDLE;
      rnd_ctr_q <= '0;
      rnd_lim_q <= NumRnd128;
    end else begin
      state_q   <= state_d;
      rnd_ctr_q <= rnd_ctr_d;
      rnd_lim_q <= rnd_lim_d;
    end
  end

endmodule

// File: hdl/aes_sp2v_chk.sv
// Encoding checker for the sparse handshake inputs and the key length
// Splits the handshake inputs into one struct per rail

`timescale 1ns/1ns

module aes_sp2v_chk import aes_ctrl_pkg::*; (
  input  sp2v_e                     in_valid_i,
  input  sp2v_e                     out_ready_i,
  input  key_len_e                  key_len_i,
  input  logic                      accept_i,    // Rail 0 ready bit

  output rail_in_t [Sp2VWidth-1:0]  rail_in_o,
  output logic                      sp_enc_err_o
);

  logic in_valid_err;
  logic out_ready_err;
  logic key_len_err;
  logic key_len_used;

  // Handshake inputs must carry one of the two legal codes at all times
  assign in_valid_err  = !(in_valid_i inside {SP2V_HIGH, SP2V_LOW});
  assign out_ready_err = !(out_ready_i inside {SP2V_HIGH, SP2V_LOW});

  // Key length only matters when a block is taken in
  assign key_len_used = accept_i && (in_valid_i == SP2V_HIGH);
  assign key_len_err  = key_len_used &&
                        !(key_len_i inside {AES_128, AES_192, AES_256});

  assign sp_enc_err_o = in_valid_err | out_ready_err | key_len_err;

  ////////////////////////////////////////////////////////////////////////////
  // Per-rail slicing
  ////////////////////////////////////////////////////////////////////////////

  // Bad codes pass through as they are, so the rails split on them as well
  always_comb begin : slice_rails
    for (int i = 0; i < Sp2VWidth; i++) begin
      rail_in_o[i].in_valid  = in_valid_i[i];
      rail_in_o[i].out_ready = out_ready_i[i];
    end
  end

endmodule

// File: hdl/aes_ctrl_pkg.sv
// Shared types for the AES round sequencer
// Sparse handshake encoding, key length, datapath selectors
// and the per-rail command and input structs

package aes_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sparse two-valued encoding
  ////////////////////////////////////////////////////////////////////////////

  // One rail per bit of a sparse signal
  parameter int Sp2VWidth = 3;

  typedef enum logic [Sp2VWidth-1:0] {
    SP2V_HIGH = 3'b011,
    SP2V_LOW  = 3'b100
  } sp2v_e;

  // Rail bits that are active-high in SP2V_HIGH
  parameter logic [Sp2VWidth-1:0] SP2V_LOGIC_HIGH = 3'b011;

  ////////////////////////////////////////////////////////////////////////////
  // Key length and round counter
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    AES_128 = 3'b001,
    AES_192 = 3'b010,
    AES_256 = 3'b100
  } key_len_e;

  parameter int RndCtrWidth = 4; // Enough for 14 rounds

  ////////////////////////////////////////////////////////////////////////////
  // Datapath selectors, one-hot
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    STATE_INIT  = 3'b001, // Load plaintext
    STATE_ROUND = 3'b010, // Full round
    STATE_FINAL = 3'b100  // Last round, no MixColumns
  } state_sel_e;

  typedef enum logic [2:0] {
    ADD_RK_INIT  = 3'b001,
    ADD_RK_ROUND = 3'b010,
    ADD_RK_FINAL = 3'b100
  } add_rk_sel_e;

  // Datapath commands of one rail, and of all rails once combined
  typedef struct packed {
    state_sel_e             state_sel;
    logic                   state_we;
    add_rk_sel_e            add_rk_sel;
    logic                   key_expand_en;
    logic [RndCtrWidth-1:0] rnd_ctr;
  } cipher_ctrl_t;

  // One rail's bits of the checked handshake inputs
  typedef struct packed {
    logic in_valid;
    logic out_ready;
  } rail_in_t;

endpackage
